/* vlog.f */
hw/md_ops_pkg.sv
hw/md_fsm_pkg.sv
hw/md_ctrl.sv
hw/mult_mac.sv
hw/div_long.sv
hw/multdiv_top.sv
tests/tb_clk_gen.sv
tests/tb_multdiv.sv

/* Bender.yml */
package:
  name: multdiv

sources:
  - hw/md_ops_pkg.sv
  - hw/md_fsm_pkg.sv
  - hw/md_ctrl.sv
  - hw/mult_mac.sv
  - hw/div_long.sv
  - hw/multdiv_top.sv
  - target: test
    files:
      - tests/tb_clk_gen.sv
      - tests/tb_multdiv.sv

/* tests/tb_multdiv.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Multiply/divide unit testbench
// Directed tests against a reference model built from the RISC-V M rules
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_multdiv;

  localparam int Timeout = 100;

  logic                             clk_i;
  logic                             rst_ni;
  logic                             start_i;
  md_ops_pkg::md_op_e               op_i;
  logic [1:0]                       signed_mode_i;
  logic [md_ops_pkg::WordWidth-1:0] op_a_i;
  logic [md_ops_pkg::WordWidth-1:0] op_b_i;
  logic                             ready_i;
  logic                             busy_o;
  logic                             valid_o;
  logic [md_ops_pkg::WordWidth-1:0] result_o;
  integer                           seed = 49;

  tb_clk_gen #(
    .PeriodNs    (20),
    .ResetCycles (10)
  ) u_tb_clk_gen (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  multdiv_top u_multdiv_top (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .start_i       (start_i),
    .op_i          (op_i),
    .signed_mode_i (signed_mode_i),
    .op_a_i        (op_a_i),
    .op_b_i        (op_b_i),
    .ready_i       (ready_i),
    .busy_o        (busy_o),
    .valid_o       (valid_o),
    .result_o      (result_o)
  );

  // Low or high word of the 64-bit product of the extended operands
  function automatic logic [31:0] mul_expected(input md_ops_pkg::md_op_e op,
                                               input logic [1:0] mode,
                                               input logic [31:0] a,
                                               input logic [31:0] b);
    logic [63:0] ext_a;
    logic [63:0] ext_b;
    logic [63:0] prod;
    ext_a = {{32{mode[md_ops_pkg::SignedA] & a[31]}}, a};
    ext_b = {{32{mode[md_ops_pkg::SignedB] & b[31]}}, b};
    prod  = ext_a * ext_b;
    if (op == md_ops_pkg::MD_OP_MULL) begin
      return prod[31:0];
    end
    return prod[63:32];
  endfunction

  // Quotient truncates toward zero, remainder follows the dividend sign
  function automatic logic [31:0] div_expected(input md_ops_pkg::md_op_e op,
                                               input logic [1:0] mode,
                                               input logic [31:0] a,
                                               input logic [31:0] b);
    logic        sa;
    logic        sb;
    logic [31:0] mag_a;
    logic [31:0] mag_b;
    logic [31:0] q;
    logic [31:0] r;
    sa = mode[md_ops_pkg::SignedA] & a[31];
    sb = mode[md_ops_pkg::SignedB] & b[31];
    if (b == 32'h0) begin
      return (op == md_ops_pkg::MD_OP_DIV) ? 32'hFFFF_FFFF : a;
    end
    if (mode == 2'b11 && a == 32'h8000_0000 && b == 32'hFFFF_FFFF) begin
      return (op == md_ops_pkg::MD_OP_DIV) ? a : 32'h0;
    end
    mag_a = sa ? -a : a;
    mag_b = sb ? -b : b;
    q = mag_a / mag_b;
    r = mag_a % mag_b;
    if (sa ^ sb) begin
      q = -q;
    end
    if (sa) begin
      r = -r;
    end
    return (op == md_ops_pkg::MD_OP_DIV) ? q : r;
  endfunction

  function automatic logic [31:0] expected_result(input md_ops_pkg::md_op_e op,
                                                  input logic [1:0] mode,
                                                  input logic [31:0] a,
                                                  input logic [31:0] b);
    if (op == md_ops_pkg::MD_OP_MULL || op == md_ops_pkg::MD_OP_MULH) begin
      return mul_expected(op, mode, a, b);
    end
    return div_expected(op, mode, a, b);
  endfunction

  task automatic abort_test(input string reason);
    $display("%s", reason);
    $display("Testbench failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
    else abort_test($sformatf("error: %s expected %08h actual %08h", name, expected, actual));
  endtask

  // Called on a falling edge
  task automatic wait_idle(input string name);
    int n;
    n = 0;
    while (busy_o !== 1'b0) begin
      @(negedge clk_i);
      n++;
      assert (n < Timeout)
      else abort_test($sformatf("timeout waiting for busy_o to fall in %s", name));
    end
  endtask

  // Counts rising edges after the start edge until valid_o shows
  task automatic wait_valid(input string name, output int lat);
    bit seen;
    seen = 1'b0;
    lat  = 0;
    while (!seen) begin
      @(negedge clk_i);
      start_i = 1'b0;
      if (valid_o === 1'b1) begin
        seen = 1'b1;
      end else begin
        lat++;
        assert (lat < Timeout)
        else abort_test($sformatf("timeout waiting for valid_o in %s", name));
      end
    end
  endtask

  task automatic issue_and_wait(input string name, input md_ops_pkg::md_op_e op,
                                input logic [1:0] mode, input logic [31:0] a,
                                input logic [31:0] b, output logic [31:0] res,
                                output int lat);
    wait_idle(name);
    op_i          = op;
    signed_mode_i = mode;
    op_a_i        = a;
    op_b_i        = b;
    start_i       = 1'b1;
    @(posedge clk_i);
    wait_valid(name, lat);
    res = result_o;
  endtask

  task automatic run_expect(input string name, input md_ops_pkg::md_op_e op,
                            input logic [1:0] mode, input logic [31:0] a,
                            input logic [31:0] b, input logic [31:0] expected);
    logic [31:0] res;
    int          lat;
    issue_and_wait(name, op, mode, a, b, res, lat);
    check_value(name, expected, res);
  endtask

  task automatic run_and_check(input string name, input md_ops_pkg::md_op_e op,
                               input logic [1:0] mode, input logic [31:0] a,
                               input logic [31:0] b);
    run_expect(name, op, mode, a, b, expected_result(op, mode, a, b));
  endtask

  task automatic test_mul_random();
    logic [31:0] a;
    logic [31:0] b;
    int          mode;
    int          i;
    for (mode = 0; mode < 4; mode++) begin
      for (i = 0; i < 8; i++) begin
        a = $random(seed);
        b = $random(seed);
        // Extreme operands on the first passes
        if (i == 0) begin
          a = 32'h8000_0000;
          b = 32'hFFFF_FFFF;
        end
        if (i == 1) begin
          a = 32'hFFFF_FFFF;
          b = 32'hFFFF_FFFF;
        end
        run_and_check($sformatf("mull_m%0d_%0d", mode, i), md_ops_pkg::MD_OP_MULL,
                      2'(mode), a, b);
        run_and_check($sformatf("mulh_m%0d_%0d", mode, i), md_ops_pkg::MD_OP_MULH,
                      2'(mode), a, b);
      end
    end
  endtask

  task automatic test_div_random();
    logic [31:0] a;
    logic [31:0] b;
    logic [1:0]  mode;
    int          s;
    int          i;
    for (s = 0; s < 2; s++) begin
      mode = (s == 1) ? 2'b11 : 2'b00;
      for (i = 0; i < 10; i++) begin
        a = $random(seed);
        b = $random(seed);
        // Small divisors give wide quotients
        if (i % 2 == 1) begin
          b = {{24{b[31]}}, b[7:0]};
        end
        if (b == 32'h0) begin
          b = 32'd3;
        end
        run_and_check($sformatf("div_s%0d_%0d", s, i), md_ops_pkg::MD_OP_DIV, mode, a, b);
        run_and_check($sformatf("rem_s%0d_%0d", s, i), md_ops_pkg::MD_OP_REM, mode, a, b);
      end
    end
  endtask

  task automatic test_div_by_zero();
    logic [31:0] a;
    logic [1:0]  mode;
    int          s;
    for (s = 0; s < 2; s++) begin
      mode = (s == 1) ? 2'b11 : 2'b00;
      a    = $random(seed);
      run_expect($sformatf("div_zero_s%0d", s), md_ops_pkg::MD_OP_DIV, mode, a, 32'h0,
                 32'hFFFF_FFFF);
      run_expect($sformatf("rem_zero_s%0d", s), md_ops_pkg::MD_OP_REM, mode, a, 32'h0, a);
      run_expect($sformatf("rem_zero_min_s%0d", s), md_ops_pkg::MD_OP_REM, mode,
                 32'h8000_0000, 32'h0, 32'h8000_0000);
    end
  endtask

  task automatic test_div_overflow();
    run_expect("div_overflow", md_ops_pkg::MD_OP_DIV, 2'b11, 32'h8000_0000, 32'hFFFF_FFFF,
               32'h8000_0000);
    run_expect("rem_overflow", md_ops_pkg::MD_OP_REM, 2'b11, 32'h8000_0000, 32'hFFFF_FFFF,
               32'h0);
    // Same operands read as unsigned
    run_and_check("div_min_unsigned", md_ops_pkg::MD_OP_DIV, 2'b00, 32'h8000_0000,
                  32'hFFFF_FFFF);
    run_and_check("rem_min_unsigned", md_ops_pkg::MD_OP_REM, 2'b00, 32'h8000_0000,
                  32'hFFFF_FFFF);
  endtask

  task automatic test_back_pressure();
    md_ops_pkg::md_op_e op;
    logic [31:0]        a;
    logic [31:0]        b;
    logic [31:0]        held;
    int                 lat;
    int                 k;
    int                 i;
    string              name;
    for (k = 0; k < 2; k++) begin
      op   = (k == 0) ? md_ops_pkg::MD_OP_MULH : md_ops_pkg::MD_OP_DIV;
      name = $sformatf("back_pressure_%0d", k);
      a    = $random(seed);
      b    = $random(seed);
      wait_idle(name);
      ready_i = 1'b0;
      issue_and_wait(name, op, 2'b11, a, b, held, lat);
      check_value(name, expected_result(op, 2'b11, a, b), held);
      for (i = 0; i < 6; i++) begin
        @(negedge clk_i);
        assert (valid_o === 1'b1 && busy_o === 1'b1)
        else abort_test($sformatf("valid_o or busy_o dropped while ready_i was low in %s",
                                  name));
        check_value(name, held, result_o);
      end
      ready_i = 1'b1;
      wait_idle(name);
      run_and_check($sformatf("after_%s", name), md_ops_pkg::MD_OP_MULL, 2'b00, b, a);
    end
  endtask

  task automatic test_mul_latency();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    int          lat;
    int          mode;
    for (mode = 0; mode < 4; mode += 3) begin
      a = $random(seed);
      b = $random(seed);
      issue_and_wait("latency_mull", md_ops_pkg::MD_OP_MULL, 2'(mode), a, b, res, lat);
      check_value("latency_mull", mul_expected(md_ops_pkg::MD_OP_MULL, 2'(mode), a, b), res);
      check_value("latency_mull_cycles", 32'd3, 32'(lat));
      issue_and_wait("latency_mulh", md_ops_pkg::MD_OP_MULH, 2'(mode), a, b, res, lat);
      check_value("latency_mulh", mul_expected(md_ops_pkg::MD_OP_MULH, 2'(mode), a, b), res);
      check_value("latency_mulh_cycles", 32'd4, 32'(lat));
    end
  endtask

  initial begin
    int n;
    start_i       = 1'b0;
    op_i          = md_ops_pkg::MD_OP_MULL;
    signed_mode_i = 2'b00;
    op_a_i        = '0;
    op_b_i        = '0;
    ready_i       = 1'b1;
    n             = 0;
    while (rst_ni !== 1'b1) begin
      @(negedge clk_i);
      n++;
      assert (n < Timeout)
      else abort_test("reset was never released");
    end
    @(negedge clk_i);
    assert (busy_o === 1'b0 && valid_o === 1'b0)
    else abort_test("busy_o or valid_o is not low after reset");

    test_mul_random();
    test_div_random();
    test_div_by_zero();
    test_div_overflow();
    test_back_pressure();
    test_mul_latency();

    $display("Testbench passed");
    $finish;
  end

endmodule

/* tests/tb_clk_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset
// Free-running clock and an active-low reset held for a set number of cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned PeriodNs    = 20,
  parameter int unsigned ResetCycles = 10
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Release away from the rising edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

/* hw/multdiv_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Multiply/divide unit
// Controller with an iterative multiplier and a long divider
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module multdiv_top (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             start_i,
  input  md_ops_pkg::md_op_e               op_i,
  input  logic [1:0]                       signed_mode_i,
  input  logic [md_ops_pkg::WordWidth-1:0] op_a_i,
  input  logic [md_ops_pkg::WordWidth-1:0] op_b_i,
  input  logic                             ready_i,
  output logic                             busy_o,
  output logic                             valid_o,
  output logic [md_ops_pkg::WordWidth-1:0] result_o
);

  md_ops_pkg::md_op_e               op;
  logic [1:0]                       signed_mode;
  logic [md_ops_pkg::WordWidth-1:0] op_a;
  logic [md_ops_pkg::WordWidth-1:0] op_b;
  logic                             mult_en;
  logic                             div_en;
  logic                             mult_valid;
  logic [md_ops_pkg::WordWidth-1:0] mult_result;
  logic                             div_valid;
  logic [md_ops_pkg::WordWidth-1:0] div_result;

  md_ctrl u_md_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .start_i       (start_i),
    .op_i          (op_i),
    .signed_mode_i (signed_mode_i),
    .op_a_i        (op_a_i),
    .op_b_i        (op_b_i),
    .ready_i       (ready_i),
    .mult_valid_i  (mult_valid),
    .mult_result_i (mult_result),
    .div_valid_i   (div_valid),
    .div_result_i  (div_result),
    .busy_o        (busy_o),
    .op_o          (op),
    .signed_mode_o (signed_mode),
    .op_a_o        (op_a),
    .op_b_o        (op_b),
    .mult_en_o     (mult_en),
    .div_en_o      (div_en),
    .valid_o       (valid_o),
    .result_o      (result_o)
  );

  mult_mac u_mult_mac (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .en_i          (mult_en),
    .op_i          (op),
    .signed_mode_i (signed_mode),
    .op_a_i        (op_a),
    .op_b_i        (op_b),
    .ready_i       (ready_i),
    .valid_o       (mult_valid),
    .result_o      (mult_result)
  );

  div_long u_div_long (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .en_i          (div_en),
    .op_i          (op),
    .signed_mode_i (signed_mode),
    .op_a_i        (op_a),
    .op_b_i        (op_b),
    .ready_i       (ready_i),
    .valid_o       (div_valid),
    .result_o      (div_result)
  );

endmodule

/* hw/div_long.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Long divider
// Restoring division on absolute values with a final sign fix
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module div_long (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             en_i,
  input  md_ops_pkg::md_op_e               op_i,
  input  logic [1:0]                       signed_mode_i,
  input  logic [md_ops_pkg::WordWidth-1:0] op_a_i,
  input  logic [md_ops_pkg::WordWidth-1:0] op_b_i,
  input  logic                             ready_i,
  output logic                             valid_o,
  output logic [md_ops_pkg::WordWidth-1:0] result_o
);

  localparam int unsigned Word     = md_ops_pkg::WordWidth;
  localparam int unsigned CntWidth = $clog2(Word);

  md_fsm_pkg::div_state_e state_q, state_d;

  logic [CntWidth-1:0] counter_q, counter_d;
  logic [Word-1:0]     rem_q, rem_d;
  logic [Word-1:0]     quo_q, quo_d;
  logic [Word-1:0]     num_q, num_d;
  logic [Word-1:0]     den_q, den_d;
  logic [Word-1:0]     sub_a;
  logic [Word-1:0]     sub_b;
  logic [Word-1:0]     sub_res;
  logic [Word-1:0]     one_shift;
  logic [Word-1:0]     next_remainder;
  logic [Word-1:0]     next_quotient;
  logic                is_greater_equal;
  logic                sign_a;
  logic                sign_b;
  logic                div_change_sign;
  logic                rem_change_sign;
  logic                is_div;
  logic                div_by_zero;

  assign is_div      = (op_i == md_ops_pkg::MD_OP_DIV);
  assign div_by_zero = (op_b_i == '0);

  assign sign_a          = signed_mode_i[md_ops_pkg::SignedA] & op_a_i[Word-1];
  assign sign_b          = signed_mode_i[md_ops_pkg::SignedB] & op_b_i[Word-1];
  assign div_change_sign = sign_a ^ sign_b;
  assign rem_change_sign = sign_a;

  // Shared subtractor for negation and the compare steps
  assign sub_res = sub_a - sub_b;

  // Signs differ means the unsigned order follows the remainder MSB
  always_comb begin
    if ((rem_q[Word-1] ^ den_q[Word-1]) == 1'b0) begin
      is_greater_equal = ~sub_res[Word-1];
    end else begin
      is_greater_equal = rem_q[Word-1];
    end
  end

  assign one_shift      = {{(Word-1){1'b0}}, 1'b1} << counter_q;
  assign next_remainder = is_greater_equal ? sub_res : rem_q;
  assign next_quotient  = is_greater_equal ? (quo_q | one_shift) : quo_q;

  always_comb begin
    state_d   = state_q;
    counter_d = counter_q;
    rem_d     = rem_q;
    quo_d     = quo_q;
    num_d     = num_q;
    den_d     = den_q;
    sub_a     = '0;
    sub_b     = op_b_i;

    case (state_q)
      md_fsm_pkg::DIV_IDLE: begin
        // Zero divisor skips straight to the result
        rem_d     = is_div ? '1 : op_a_i;
        state_d   = div_by_zero ? md_fsm_pkg::DIV_FINISH : md_fsm_pkg::DIV_ABS_A;
        counter_d = CntWidth'(Word - 1);
      end

      md_fsm_pkg::DIV_ABS_A: begin
        sub_b     = op_a_i;
        quo_d     = '0;
        num_d     = sign_a ? sub_res : op_a_i;
        state_d   = md_fsm_pkg::DIV_ABS_B;
        counter_d = CntWidth'(Word - 1);
      end

      md_fsm_pkg::DIV_ABS_B: begin
        sub_b     = op_b_i;
        rem_d     = {{(Word-1){1'b0}}, num_q[Word-1]};
        den_d     = sign_b ? sub_res : op_b_i;
        state_d   = md_fsm_pkg::DIV_COMP;
        counter_d = CntWidth'(Word - 1);
      end

      md_fsm_pkg::DIV_COMP: begin
        sub_a     = rem_q;
        sub_b     = den_q;
        counter_d = counter_q - 1'b1;
        // Shift in the next numerator bit
        rem_d     = {next_remainder[Word-2:0], num_q[counter_d]};
        quo_d     = next_quotient;
        state_d   = (counter_q == CntWidth'(1)) ? md_fsm_pkg::DIV_LAST : md_fsm_pkg::DIV_COMP;
      end

      md_fsm_pkg::DIV_LAST: begin
        sub_a     = rem_q;
        sub_b     = den_q;
        counter_d = counter_q - 1'b1;
        rem_d     = is_div ? next_quotient : next_remainder;
        state_d   = md_fsm_pkg::DIV_CHANGE_SIGN;
      end

      md_fsm_pkg::DIV_CHANGE_SIGN: begin
        sub_b = rem_q;
        if (is_div) begin
          rem_d = div_change_sign ? sub_res : rem_q;
        end else begin
          rem_d = rem_change_sign ? sub_res : rem_q;
        end
        state_d = md_fsm_pkg::DIV_FINISH;
      end

      md_fsm_pkg::DIV_FINISH: begin
        if (ready_i) begin
          state_d = md_fsm_pkg::DIV_IDLE;
        end
      end

      default: begin
        state_d = md_fsm_pkg::DIV_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= md_fsm_pkg::DIV_IDLE;
      counter_q <= '0;
    end else if (en_i) begin
      state_q   <= state_d;
      counter_q <= counter_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (en_i) begin
      rem_q <= rem_d;
      quo_q <= quo_d;
      num_q <= num_d;
      den_q <= den_d;
    end
  end

  assign valid_o  = (state_q == md_fsm_pkg::DIV_FINISH);
  assign result_o = rem_q;

endmodule

/* hw/mult_mac.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Iterative MAC multiplier
// One 17x17 signed multiply-accumulate walked over the half-word products
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mult_mac (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             en_i,
  input  md_ops_pkg::md_op_e               op_i,
  input  logic [1:0]                       signed_mode_i,
  input  logic [md_ops_pkg::WordWidth-1:0] op_a_i,
  input  logic [md_ops_pkg::WordWidth-1:0] op_b_i,
  input  logic                             ready_i,
  output logic                             valid_o,
  output logic [md_ops_pkg::WordWidth-1:0] result_o
);

  localparam int unsigned Word     = md_ops_pkg::WordWidth;
  localparam int unsigned Half     = md_ops_pkg::HalfWidth;
  localparam int unsigned AccWidth = Word + 2;

  md_fsm_pkg::mult_state_e state_q, state_d;

  logic [Half-1:0]     mult_op_a;
  logic [Half-1:0]     mult_op_b;
  logic                sign_a;
  logic                sign_b;
  logic [AccWidth-1:0] accum;
  logic [AccWidth-1:0] mac_res;
  logic [AccWidth-1:0] accum_q, accum_d;
  logic                done_q, done_d;
  logic                is_mull;
  logic                signed_mult;

  assign is_mull     = (op_i == md_ops_pkg::MD_OP_MULL);
  assign signed_mult = |signed_mode_i;

  // Top two bits of the full sum are equal, so 34 bits hold it
  assign mac_res = $signed({sign_a, mult_op_a}) * $signed({sign_b, mult_op_b}) + $signed(accum);

  always_comb begin
    mult_op_a = op_a_i[Half-1:0];
    mult_op_b = op_b_i[Half-1:0];
    sign_a    = 1'b0;
    sign_b    = 1'b0;
    accum     = accum_q;
    accum_d   = mac_res;
    state_d   = state_q;
    done_d    = done_q;

    case (state_q)
      md_fsm_pkg::ALBL: begin
        accum   = '0;
        state_d = md_fsm_pkg::ALBH;
      end

      md_fsm_pkg::ALBH: begin
        mult_op_b = op_b_i[Word-1:Half];
        sign_b    = signed_mode_i[md_ops_pkg::SignedB] & op_b_i[Word-1];
        // Low product is unsigned with no carry out
        accum     = {{(AccWidth-Half){1'b0}}, accum_q[Word-1:Half]};
        if (is_mull) begin
          accum_d = {2'b00, mac_res[Half-1:0], accum_q[Half-1:0]};
        end
        state_d = md_fsm_pkg::AHBL;
      end

      md_fsm_pkg::AHBL: begin
        mult_op_a = op_a_i[Word-1:Half];
        sign_a    = signed_mode_i[md_ops_pkg::SignedA] & op_a_i[Word-1];
        if (is_mull) begin
          accum   = {{(AccWidth-Half){1'b0}}, accum_q[Word-1:Half]};
          accum_d = {2'b00, mac_res[Half-1:0], accum_q[Half-1:0]};
          if (!done_q) begin
            done_d = 1'b1;
          end else if (ready_i) begin
            done_d  = 1'b0;
            state_d = md_fsm_pkg::ALBL;
          end
        end else begin
          state_d = md_fsm_pkg::AHBH;
        end
      end

      md_fsm_pkg::AHBH: begin
        mult_op_a = op_a_i[Word-1:Half];
        mult_op_b = op_b_i[Word-1:Half];
        sign_a    = signed_mode_i[md_ops_pkg::SignedA] & op_a_i[Word-1];
        sign_b    = signed_mode_i[md_ops_pkg::SignedB] & op_b_i[Word-1];
        // Carry the middle sum down by a half word
        accum     = {{Half{signed_mult & accum_q[AccWidth-1]}}, accum_q[AccWidth-1:Half]};
        if (!done_q) begin
          done_d = 1'b1;
        end else if (ready_i) begin
          done_d  = 1'b0;
          state_d = md_fsm_pkg::ALBL;
        end
      end

      default: begin
        state_d = md_fsm_pkg::ALBL;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= md_fsm_pkg::ALBL;
      done_q  <= 1'b0;
    end else if (en_i) begin
      state_q <= state_d;
      done_q  <= done_d;
    end
  end

  // Accumulator freezes once the result is in
  always_ff @(posedge clk_i) begin
    if (en_i && !done_q) begin
      accum_q <= accum_d;
    end
  end

  assign valid_o  = done_q;
  assign result_o = accum_q[Word-1:0];

endmodule

/* hw/md_ctrl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Multiply/divide controller
// Captures a request, enables one unit and forwards its result
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module md_ctrl (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             start_i,
  input  md_ops_pkg::md_op_e               op_i,
  input  logic [1:0]                       signed_mode_i,
  input  logic [md_ops_pkg::WordWidth-1:0] op_a_i,
  input  logic [md_ops_pkg::WordWidth-1:0] op_b_i,
  input  logic                             ready_i,
  input  logic                             mult_valid_i,
  input  logic [md_ops_pkg::WordWidth-1:0] mult_result_i,
  input  logic                             div_valid_i,
  input  logic [md_ops_pkg::WordWidth-1:0] div_result_i,
  output logic                             busy_o,
  output md_ops_pkg::md_op_e               op_o,
  output logic [1:0]                       signed_mode_o,
  output logic [md_ops_pkg::WordWidth-1:0] op_a_o,
  output logic [md_ops_pkg::WordWidth-1:0] op_b_o,
  output logic                             mult_en_o,
  output logic                             div_en_o,
  output logic                             valid_o,
  output logic [md_ops_pkg::WordWidth-1:0] result_o
);

  logic                             busy_q;
  md_ops_pkg::md_op_e               op_q;
  logic [1:0]                       mode_q;
  logic [md_ops_pkg::WordWidth-1:0] op_a_q;
  logic [md_ops_pkg::WordWidth-1:0] op_b_q;
  logic                             sel_mult;
  logic                             accept;

  assign accept   = start_i & ~busy_q;
  assign sel_mult = (op_q == md_ops_pkg::MD_OP_MULL) || (op_q == md_ops_pkg::MD_OP_MULH);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      op_q   <= md_ops_pkg::MD_OP_MULL;
    end else if (accept) begin
      busy_q <= 1'b1;
      op_q   <= op_i;
    end else if (busy_q && valid_o && ready_i) begin
      // Result consumed, release the unit
      busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      mode_q <= signed_mode_i;
      op_a_q <= op_a_i;
      op_b_q <= op_b_i;
    end
  end

  assign busy_o        = busy_q;
  assign op_o          = op_q;
  assign signed_mode_o = mode_q;
  assign op_a_o        = op_a_q;
  assign op_b_o        = op_b_q;

  // Enables stay high for the whole request
  assign mult_en_o = busy_q & sel_mult;
  assign div_en_o  = busy_q & ~sel_mult;

  assign valid_o  = sel_mult ? mult_valid_i : div_valid_i;
  assign result_o = sel_mult ? mult_result_i : div_result_i;

endmodule

/* hw/md_fsm_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Multiply/divide state machines
// State encodings of the MAC multiplier and the long divider
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package md_fsm_pkg;

  // One state per half-word partial product
  typedef enum logic [1:0] {
    ALBL,
    ALBH,
    AHBL,
    AHBH
  } mult_state_e;

  // Long division steps
  typedef enum logic [2:0] {
    DIV_IDLE,
    DIV_ABS_A,
    DIV_ABS_B,
    DIV_COMP,
    DIV_LAST,
    DIV_CHANGE_SIGN,
    DIV_FINISH
  } div_state_e;

endpackage

/* hw/md_ops_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Multiply/divide operations
// Word widths, operation codes and the signed-mode bit positions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package md_ops_pkg;

  // Operand and result width
  localparam int unsigned WordWidth = 32;

  // One multiplier operand half
  localparam int unsigned HalfWidth = 16;

  // Bit positions within the 2-bit signed mode
  localparam int unsigned SignedA = 0;
  localparam int unsigned SignedB = 1;

  // Operations
  typedef enum logic [1:0] {
    MD_OP_MULL = 2'b00,
    MD_OP_MULH = 2'b01,
    MD_OP_DIV  = 2'b10,
    MD_OP_REM  = 2'b11
  } md_op_e;

endpackage
